// File: axil_mem_macros.svh
// Bus widths, memory depth and response codes of the AXI-lite memory
`ifndef AXIL_MEM_MACROS_SVH
`define AXIL_MEM_MACROS_SVH

// ---------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 64
`define AXIL_STRB_W 8

// ---------------------------------------------------------------------
// SRAM geometry
// ---------------------------------------------------------------------
// Depth in 64-bit words
`define MEM_DEPTH 1024
`define MEM_IDX_W 10

// ---------------------------------------------------------------------
// AXI response codes
// ---------------------------------------------------------------------
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

// File: axil_mem_pkg.sv
// Vector typedefs and state enums of the AXI-lite memory subsystem
`default_nettype none

`include "axil_mem_macros.svh"

package axil_mem_pkg;

  // Bus payload types
  typedef logic [`AXIL_ADDR_W-1:0] addr_t;
  typedef logic [`AXIL_DATA_W-1:0] data_t;
  typedef logic [`AXIL_STRB_W-1:0] strb_t;
  typedef logic [1:0]              resp_t;

  // Word index into the SRAM
  typedef logic [`MEM_IDX_W-1:0] mem_idx_t;

  // Slave read channel FSM
  typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

  // Slave write channel FSM
  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;

  // Read arbiter
  typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_e;

endpackage

`default_nettype wire

// File: sram_bytewise.sv
// Word-addressed synchronous SRAM model with byte write enables
`default_nettype none

`include "axil_mem_macros.svh"

module sram_bytewise (
  input  wire logic                   i_aclk,
  // Write port
  input  wire logic                   i_we,
  input  wire axil_mem_pkg::mem_idx_t i_widx,
  input  wire axil_mem_pkg::data_t    i_wdata,
  input  wire axil_mem_pkg::strb_t    i_wstrb,
  // Read port
  input  wire logic                   i_re,
  input  wire axil_mem_pkg::mem_idx_t i_ridx,
  output axil_mem_pkg::data_t         o_rdata
);

  axil_mem_pkg::data_t mem [`MEM_DEPTH];

  // ---------------------------------------------------------------------
  // Byte-strobed write
  // ---------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_we) begin
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[i_widx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Registered read
  // ---------------------------------------------------------------------
  // Same-edge write to the read word returns the old contents
  always_ff @(posedge i_aclk) begin
    if (i_re) begin
      o_rdata <= mem[i_ridx];
    end
  end

endmodule

`default_nettype wire

// File: axil_sram_slave.sv
// AXI-lite slave with read/write FSMs, range check and responses over an SRAM
`default_nettype none

`include "axil_mem_macros.svh"

module axil_sram_slave (
  input  wire logic                   i_aclk,
  input  wire logic                   i_arst_n,
  // Write address channel
  input  wire logic                   i_awvalid,
  output logic                        o_awready,
  input  wire axil_mem_pkg::addr_t    i_awaddr,
  input  wire logic [2:0]             i_awprot,
  // Write data channel
  input  wire logic                   i_wvalid,
  output logic                        o_wready,
  input  wire axil_mem_pkg::data_t    i_wdata,
  input  wire axil_mem_pkg::strb_t    i_wstrb,
  // Write response channel
  output logic                        o_bvalid,
  input  wire logic                   i_bready,
  output axil_mem_pkg::resp_t         o_bresp,
  // Read address channel
  input  wire logic                   i_arvalid,
  output logic                        o_arready,
  input  wire axil_mem_pkg::addr_t    i_araddr,
  input  wire logic [2:0]             i_arprot,
  // Read data channel
  output logic                        o_rvalid,
  input  wire logic                   i_rready,
  output axil_mem_pkg::data_t         o_rdata,
  output axil_mem_pkg::resp_t         o_rresp,
  // SRAM side
  output logic                        o_mem_we,
  output axil_mem_pkg::mem_idx_t      o_mem_widx,
  output axil_mem_pkg::data_t         o_mem_wdata,
  output axil_mem_pkg::strb_t         o_mem_wstrb,
  output logic                        o_mem_re,
  output axil_mem_pkg::mem_idx_t      o_mem_ridx,
  input  wire axil_mem_pkg::data_t    i_mem_rdata
);

  // Protection attributes are accepted but not checked
  axil_mem_pkg::rd_state_e rd_state;
  axil_mem_pkg::wr_state_e wr_state;
  axil_mem_pkg::addr_t     awaddr_q;
  axil_mem_pkg::resp_t     bresp_q;
  logic                    rd_err_q;
  logic                    aw_fire, w_fire, b_fire, ar_fire, r_fire;
  logic                    ar_in_range, aw_in_range;

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  // Low three address bits select a byte within the word and are ignored
  assign ar_in_range = i_araddr[`AXIL_ADDR_W-1:3] < `MEM_DEPTH;
  assign aw_in_range = awaddr_q[`AXIL_ADDR_W-1:3] < `MEM_DEPTH;

  // ---------------------------------------------------------------------
  // Read channel
  // ---------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_state <= axil_mem_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        axil_mem_pkg::RD_IDLE: if (ar_fire) rd_state <= axil_mem_pkg::RD_DATA;
        axil_mem_pkg::RD_DATA: if (r_fire) rd_state <= axil_mem_pkg::RD_IDLE;
        default:               rd_state <= axil_mem_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      rd_err_q <= !ar_in_range;
    end
  end

  assign o_arready  = (rd_state == axil_mem_pkg::RD_IDLE);
  assign o_rvalid   = (rd_state == axil_mem_pkg::RD_DATA);
  // SRAM read register captures on the AR edge and holds until the next read
  assign o_mem_re   = ar_fire & ar_in_range;
  assign o_mem_ridx = i_araddr[`MEM_IDX_W+2:3];
  assign o_rdata    = rd_err_q ? '0 : i_mem_rdata;
  assign o_rresp    = rd_err_q ? `RESP_SLVERR : `RESP_OKAY;

  // ---------------------------------------------------------------------
  // Write channel
  // ---------------------------------------------------------------------
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_state <= axil_mem_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        axil_mem_pkg::WR_IDLE: if (aw_fire) wr_state <= axil_mem_pkg::WR_DATA;
        axil_mem_pkg::WR_DATA: if (w_fire) wr_state <= axil_mem_pkg::WR_RESP;
        axil_mem_pkg::WR_RESP: if (b_fire) wr_state <= axil_mem_pkg::WR_IDLE;
        default:               wr_state <= axil_mem_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      awaddr_q <= i_awaddr;
    end
    if (w_fire) begin
      bresp_q <= aw_in_range ? `RESP_OKAY : `RESP_SLVERR;
    end
  end

  assign o_awready   = (wr_state == axil_mem_pkg::WR_IDLE);
  assign o_wready    = (wr_state == axil_mem_pkg::WR_DATA);
  assign o_bvalid    = (wr_state == axil_mem_pkg::WR_RESP);
  assign o_bresp     = bresp_q;

  // Out-of-range writes are dropped here
  assign o_mem_we    = w_fire & aw_in_range;
  assign o_mem_widx  = awaddr_q[`MEM_IDX_W+2:3];
  assign o_mem_wdata = i_wdata;
  assign o_mem_wstrb = i_wstrb;

  // ---------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------
  a_rvalid_after_ar: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    $rose(o_rvalid) |-> $past(ar_fire));

  a_bvalid_after_w: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    $rose(o_bvalid) |-> $past(w_fire));

  // A word written into the SRAM is always answered with OKAY
  a_we_in_range: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    o_mem_we |=> (o_bvalid && (o_bresp == `RESP_OKAY)));

endmodule

`default_nettype wire

// File: axil_rd_arbiter.sv
// Round-robin arbiter of two AXI-lite read masters onto one read channel
`default_nettype none

`include "axil_mem_macros.svh"

module axil_rd_arbiter (
  input  wire logic                i_aclk,
  input  wire logic                i_arst_n,
  // Master 0
  input  wire logic                i_m0_arvalid,
  output logic                     o_m0_arready,
  input  wire axil_mem_pkg::addr_t i_m0_araddr,
  output logic                     o_m0_rvalid,
  input  wire logic                i_m0_rready,
  output axil_mem_pkg::data_t      o_m0_rdata,
  output axil_mem_pkg::resp_t      o_m0_rresp,
  // Master 1
  input  wire logic                i_m1_arvalid,
  output logic                     o_m1_arready,
  input  wire axil_mem_pkg::addr_t i_m1_araddr,
  output logic                     o_m1_rvalid,
  input  wire logic                i_m1_rready,
  output axil_mem_pkg::data_t      o_m1_rdata,
  output axil_mem_pkg::resp_t      o_m1_rresp,
  // Toward the slave
  output logic                     o_s_arvalid,
  input  wire logic                i_s_arready,
  output axil_mem_pkg::addr_t      o_s_araddr,
  input  wire logic                i_s_rvalid,
  output logic                     o_s_rready,
  input  wire axil_mem_pkg::data_t i_s_rdata,
  input  wire axil_mem_pkg::resp_t i_s_rresp
);

  axil_mem_pkg::arb_state_e arb_state;
  logic                     prio;
  logic                     grant;
  logic                     sel;
  logic                     idle;
  logic                     s_ar_fire;
  logic                     s_r_fire;

  assign idle      = (arb_state == axil_mem_pkg::ARB_IDLE);
  assign s_ar_fire = o_s_arvalid & i_s_arready;
  assign s_r_fire  = i_s_rvalid & o_s_rready;

  // ---------------------------------------------------------------------
  // Request selection
  // ---------------------------------------------------------------------
  // prio set means m1 wins a tie
  always_comb begin
    if (i_m0_arvalid && i_m1_arvalid) begin
      sel = prio;
    end else begin
      sel = i_m1_arvalid;
    end
  end

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      arb_state <= axil_mem_pkg::ARB_IDLE;
      prio      <= 1'b0;
      grant     <= 1'b0;
    end else begin
      case (arb_state)
        axil_mem_pkg::ARB_IDLE: begin
          if (s_ar_fire) begin
            arb_state <= axil_mem_pkg::ARB_BUSY;
            grant     <= sel;
            prio      <= ~sel;
          end
        end
        axil_mem_pkg::ARB_BUSY: begin
          if (s_r_fire) begin
            arb_state <= axil_mem_pkg::ARB_IDLE;
          end
        end
        default: arb_state <= axil_mem_pkg::ARB_IDLE;
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // AR mux and R demux
  // ---------------------------------------------------------------------
  assign o_s_arvalid  = idle & (i_m0_arvalid | i_m1_arvalid);
  assign o_s_araddr   = sel ? i_m1_araddr : i_m0_araddr;
  assign o_m0_arready = idle & ~sel & i_s_arready;
  assign o_m1_arready = idle & sel & i_s_arready;

  assign o_m0_rvalid  = ~idle & ~grant & i_s_rvalid;
  assign o_m1_rvalid  = ~idle & grant & i_s_rvalid;
  assign o_s_rready   = ~idle & (grant ? i_m1_rready : i_m0_rready);
  assign o_m0_rdata   = i_s_rdata;
  assign o_m0_rresp   = i_s_rresp;
  assign o_m1_rdata   = i_s_rdata;
  assign o_m1_rresp   = i_s_rresp;

  // Grant stays put for the whole transaction
  a_grant_stable: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    (arb_state == axil_mem_pkg::ARB_BUSY) |=>
      (arb_state == axil_mem_pkg::ARB_IDLE) || $stable(grant));

  // Slave only answers a read that was granted through here
  a_rvalid_busy: assert property (@(posedge i_aclk) disable iff (!i_arst_n)
    i_s_rvalid |-> (arb_state == axil_mem_pkg::ARB_BUSY));

endmodule

`default_nettype wire

// File: axil_mem_top.sv
// Top level with read arbiter, AXI-lite SRAM slave and SRAM model
`default_nettype none

`include "axil_mem_macros.svh"

module axil_mem_top (
  input  wire logic                i_aclk,
  input  wire logic                i_arst_n,
  // Instruction fetch read port
  input  wire logic                i_m0_arvalid,
  output logic                     o_m0_arready,
  input  wire axil_mem_pkg::addr_t i_m0_araddr,
  output logic                     o_m0_rvalid,
  input  wire logic                i_m0_rready,
  output axil_mem_pkg::data_t      o_m0_rdata,
  output axil_mem_pkg::resp_t      o_m0_rresp,
  // Load/store read port
  input  wire logic                i_m1_arvalid,
  output logic                     o_m1_arready,
  input  wire axil_mem_pkg::addr_t i_m1_araddr,
  output logic                     o_m1_rvalid,
  input  wire logic                i_m1_rready,
  output axil_mem_pkg::data_t      o_m1_rdata,
  output axil_mem_pkg::resp_t      o_m1_rresp,
  // Load/store write port
  input  wire logic                i_m1_awvalid,
  output logic                     o_m1_awready,
  input  wire axil_mem_pkg::addr_t i_m1_awaddr,
  input  wire logic [2:0]          i_m1_awprot,
  input  wire logic                i_m1_wvalid,
  output logic                     o_m1_wready,
  input  wire axil_mem_pkg::data_t i_m1_wdata,
  input  wire axil_mem_pkg::strb_t i_m1_wstrb,
  output logic                     o_m1_bvalid,
  input  wire logic                i_m1_bready,
  output axil_mem_pkg::resp_t      o_m1_bresp
);

  // Arbitrated read channel
  logic                   s_arvalid, s_arready, s_rvalid, s_rready;
  axil_mem_pkg::addr_t    s_araddr;
  axil_mem_pkg::data_t    s_rdata;
  axil_mem_pkg::resp_t    s_rresp;

  // SRAM interface
  logic                   mem_we, mem_re;
  axil_mem_pkg::mem_idx_t mem_widx, mem_ridx;
  axil_mem_pkg::data_t    mem_wdata, mem_rdata;
  axil_mem_pkg::strb_t    mem_wstrb;

  axil_rd_arbiter u_rd_arb (
    .i_aclk       (i_aclk),       .i_arst_n     (i_arst_n),
    .i_m0_arvalid (i_m0_arvalid), .o_m0_arready (o_m0_arready),
    .i_m0_araddr  (i_m0_araddr),  .o_m0_rvalid  (o_m0_rvalid),
    .i_m0_rready  (i_m0_rready),  .o_m0_rdata   (o_m0_rdata),
    .o_m0_rresp   (o_m0_rresp),
    .i_m1_arvalid (i_m1_arvalid), .o_m1_arready (o_m1_arready),
    .i_m1_araddr  (i_m1_araddr),  .o_m1_rvalid  (o_m1_rvalid),
    .i_m1_rready  (i_m1_rready),  .o_m1_rdata   (o_m1_rdata),
    .o_m1_rresp   (o_m1_rresp),
    .o_s_arvalid  (s_arvalid),    .i_s_arready  (s_arready),
    .o_s_araddr   (s_araddr),     .i_s_rvalid   (s_rvalid),
    .o_s_rready   (s_rready),     .i_s_rdata    (s_rdata),
    .i_s_rresp    (s_rresp)
  );

  // Fetch and load/store share unprivileged data access
  axil_sram_slave u_slave (
    .i_aclk     (i_aclk),       .i_arst_n   (i_arst_n),
    .i_awvalid  (i_m1_awvalid), .o_awready  (o_m1_awready),
    .i_awaddr   (i_m1_awaddr),  .i_awprot   (i_m1_awprot),
    .i_wvalid   (i_m1_wvalid),  .o_wready   (o_m1_wready),
    .i_wdata    (i_m1_wdata),   .i_wstrb    (i_m1_wstrb),
    .o_bvalid   (o_m1_bvalid),  .i_bready   (i_m1_bready),
    .o_bresp    (o_m1_bresp),
    .i_arvalid  (s_arvalid),    .o_arready  (s_arready),
    .i_araddr   (s_araddr),     .i_arprot   (3'b000),
    .o_rvalid   (s_rvalid),     .i_rready   (s_rready),
    .o_rdata    (s_rdata),      .o_rresp    (s_rresp),
    .o_mem_we   (mem_we),       .o_mem_widx (mem_widx),
    .o_mem_wdata(mem_wdata),    .o_mem_wstrb(mem_wstrb),
    .o_mem_re   (mem_re),       .o_mem_ridx (mem_ridx),
    .i_mem_rdata(mem_rdata)
  );

  sram_bytewise u_sram (
    .i_aclk  (i_aclk),
    .i_we    (mem_we),
    .i_widx  (mem_widx),
    .i_wdata (mem_wdata),
    .i_wstrb (mem_wstrb),
    .i_re    (mem_re),
    .i_ridx  (mem_ridx),
    .o_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// File: tb_axil_mem.sv
// Testbench for the AXI-lite memory top with shadow memory and concurrent checks
`default_nettype none

`include "axil_mem_macros.svh"

module tb_axil_mem;

  localparam int TIMEOUT = 50;

  logic                aclk, arst_n;
  logic                m0_arvalid, m0_arready, m0_rvalid, m0_rready;
  logic                m1_arvalid, m1_arready, m1_rvalid, m1_rready;
  logic                m1_awvalid, m1_awready, m1_wvalid, m1_wready, m1_bvalid, m1_bready;
  axil_mem_pkg::addr_t m0_araddr, m1_araddr, m1_awaddr, mon_awaddr;
  axil_mem_pkg::data_t m0_rdata, m1_rdata, m1_wdata, exp0_data, exp1_data;
  axil_mem_pkg::resp_t m0_rresp, m1_rresp, m1_bresp, exp0_resp, exp1_resp, exp_bresp;
  axil_mem_pkg::strb_t m1_wstrb;
  logic                m0_pend, m1_pend, last_grant;
  axil_mem_pkg::data_t shadow [`MEM_DEPTH];
  int unsigned         written [$];

  axil_mem_top dut0 (
    .i_aclk       (aclk),       .i_arst_n     (arst_n),
    .i_m0_arvalid (m0_arvalid), .o_m0_arready (m0_arready),
    .i_m0_araddr  (m0_araddr),  .o_m0_rvalid  (m0_rvalid),
    .i_m0_rready  (m0_rready),  .o_m0_rdata   (m0_rdata),
    .o_m0_rresp   (m0_rresp),
    .i_m1_arvalid (m1_arvalid), .o_m1_arready (m1_arready),
    .i_m1_araddr  (m1_araddr),  .o_m1_rvalid  (m1_rvalid),
    .i_m1_rready  (m1_rready),  .o_m1_rdata   (m1_rdata),
    .o_m1_rresp   (m1_rresp),
    .i_m1_awvalid (m1_awvalid), .o_m1_awready (m1_awready),
    .i_m1_awaddr  (m1_awaddr),  .i_m1_awprot  (3'b000),
    .i_m1_wvalid  (m1_wvalid),  .o_m1_wready  (m1_wready),
    .i_m1_wdata   (m1_wdata),   .i_m1_wstrb   (m1_wstrb),
    .o_m1_bvalid  (m1_bvalid),  .i_m1_bready  (m1_bready),
    .o_m1_bresp   (m1_bresp)
  );

  always #5 aclk = ~aclk;

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------
  task automatic report_fail(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    report_fail($sformatf("Fail %s expected %h actual %h", name, exp, act));
  endtask

  task automatic step_with_timeout(inout int n, input string what);
    @(posedge aclk);
    n++;
    if (n > TIMEOUT) report_fail(what);
  endtask

  function automatic logic in_range(input axil_mem_pkg::addr_t a);
    return a[`AXIL_ADDR_W-1:3] < `MEM_DEPTH;
  endfunction

  // Random byte offset within the word, ignored by the memory
  function automatic axil_mem_pkg::addr_t word_addr(input int unsigned word);
    return axil_mem_pkg::addr_t'(word) << 3 | axil_mem_pkg::addr_t'($urandom_range(7));
  endfunction

  task automatic write_word(input axil_mem_pkg::addr_t a, input axil_mem_pkg::data_t d,
                            input axil_mem_pkg::strb_t s, input axil_mem_pkg::resp_t r);
    int n;
    n = 0;
    m1_awvalid <= 1'b1;
    m1_awaddr  <= a;
    exp_bresp  <= r;
    do step_with_timeout(n, "AW handshake did not complete in time"); while (!m1_awready);
    m1_awvalid <= 1'b0;
    m1_wvalid  <= 1'b1;
    m1_wdata   <= d;
    m1_wstrb   <= s;
    n = 0;
    do step_with_timeout(n, "W handshake did not complete in time"); while (!m1_wready);
    m1_wvalid <= 1'b0;
    n = 0;
    do step_with_timeout(n, "Write response did not arrive in time"); while (!m1_bvalid);
  endtask

  // Reads on either or both masters
  // rready stays low for the first hold cycles of rvalid
  task automatic read_both(input logic en0, input logic en1, input axil_mem_pkg::addr_t a0,
                           input axil_mem_pkg::addr_t a1, input int hold);
    int   n;
    int   seen0;
    int   seen1;
    logic done0;
    logic done1;
    n     = 0;
    seen0 = 0;
    seen1 = 0;
    done0 = !en0;
    done1 = !en1;
    exp0_data  <= in_range(a0) ? shadow[a0[`MEM_IDX_W+2:3]] : '0;
    exp0_resp  <= in_range(a0) ? `RESP_OKAY : `RESP_SLVERR;
    exp1_data  <= in_range(a1) ? shadow[a1[`MEM_IDX_W+2:3]] : '0;
    exp1_resp  <= in_range(a1) ? `RESP_OKAY : `RESP_SLVERR;
    m0_arvalid <= en0;
    m0_araddr  <= a0;
    m0_rready  <= (hold == 0);
    m1_arvalid <= en1;
    m1_araddr  <= a1;
    m1_rready  <= (hold == 0);
    while (!(done0 && done1)) begin
      step_with_timeout(n, "Read response did not arrive in time");
      if (m0_arvalid && m0_arready) m0_arvalid <= 1'b0;
      if (m1_arvalid && m1_arready) m1_arvalid <= 1'b0;
      if (m0_rvalid && m0_rready) done0 = 1'b1;
      if (m1_rvalid && m1_rready) done1 = 1'b1;
      if (m0_rvalid) begin
        seen0++;
        if (seen0 >= hold) m0_rready <= 1'b1;
      end
      if (m1_rvalid) begin
        seen1++;
        if (seen1 >= hold) m1_rready <= 1'b1;
      end
    end
    m0_rready <= 1'b1;
    m1_rready <= 1'b1;
  endtask

  // ---------------------------------------------------------------------
  // Shadow memory and transaction tracking
  // ---------------------------------------------------------------------
  always @(posedge aclk) begin
    if (m1_awvalid && m1_awready) mon_awaddr <= m1_awaddr;
    if (m1_wvalid && m1_wready && in_range(mon_awaddr)) begin
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (m1_wstrb[b]) shadow[mon_awaddr[`MEM_IDX_W+2:3]][b*8 +: 8] <= m1_wdata[b*8 +: 8];
      end
    end
  end

  always @(posedge aclk) begin
    if (m0_arvalid && m0_arready) begin
      m0_pend    <= 1'b1;
      last_grant <= 1'b0;
    end
    if (m1_arvalid && m1_arready) begin
      m1_pend    <= 1'b1;
      last_grant <= 1'b1;
    end
    if (m0_rvalid && m0_rready) m0_pend <= 1'b0;
    if (m1_rvalid && m1_rready) m1_pend <= 1'b0;
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  a_m0_rdata: assert property (@(posedge aclk) disable iff (!arst_n)
    m0_rvalid |-> m0_rdata == exp0_data)
    else report_value("m0_rdata", $sampled(exp0_data), $sampled(m0_rdata));
  a_m1_rdata: assert property (@(posedge aclk) disable iff (!arst_n)
    m1_rvalid |-> m1_rdata == exp1_data)
    else report_value("m1_rdata", $sampled(exp1_data), $sampled(m1_rdata));
  a_m0_rresp: assert property (@(posedge aclk) disable iff (!arst_n)
    m0_rvalid |-> m0_rresp == exp0_resp)
    else report_value("m0_rresp", $sampled(exp0_resp), $sampled(m0_rresp));
  a_m1_rresp: assert property (@(posedge aclk) disable iff (!arst_n)
    m1_rvalid |-> m1_rresp == exp1_resp)
    else report_value("m1_rresp", $sampled(exp1_resp), $sampled(m1_rresp));
  a_m1_bresp: assert property (@(posedge aclk) disable iff (!arst_n)
    m1_bvalid |-> m1_bresp == exp_bresp)
    else report_value("m1_bresp", $sampled(exp_bresp), $sampled(m1_bresp));

  // One cycle from AR transfer to rvalid
  a_m0_latency: assert property (@(posedge aclk) disable iff (!arst_n)
    (m0_arvalid && m0_arready) |=> m0_rvalid)
    else report_fail("m0 rvalid did not rise one cycle after the AR transfer");
  a_m1_latency: assert property (@(posedge aclk) disable iff (!arst_n)
    (m1_arvalid && m1_arready) |=> m1_rvalid)
    else report_fail("m1 rvalid did not rise one cycle after the AR transfer");
  a_m0_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    (m0_rvalid && !m0_rready) |=> (m0_rvalid && $stable(m0_rdata)))
    else report_fail("m0 rvalid or rdata changed under back-pressure");
  a_m1_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    (m1_rvalid && !m1_rready) |=> (m1_rvalid && $stable(m1_rdata)))
    else report_fail("m1 rvalid or rdata changed under back-pressure");

  // A response only reaches the master whose request is outstanding
  a_m0_owner: assert property (@(posedge aclk) disable iff (!arst_n)
    m0_rvalid |-> m0_pend)
    else report_fail("m0 saw rvalid without an outstanding request");
  a_m1_owner: assert property (@(posedge aclk) disable iff (!arst_n)
    m1_rvalid |-> m1_pend)
    else report_fail("m1 saw rvalid without an outstanding request");
  a_rr_grant: assert property (@(posedge aclk) disable iff (!arst_n)
    (m0_arvalid && m1_arvalid && (m0_arready || m1_arready)) |->
      (m1_arready != last_grant) && (m0_arready == last_grant))
    else report_value("arb_grant", $sampled({!last_grant, last_grant}),
                      $sampled({m1_arready, m0_arready}));

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  initial begin
    int unsigned word;
    int unsigned alias_word;
    void'($urandom(11));
    aclk       = 1'b0;
    arst_n     = 1'b0;
    m0_arvalid = 1'b0;
    m0_araddr  = '0;
    m0_rready  = 1'b1;
    m1_arvalid = 1'b0;
    m1_araddr  = '0;
    m1_rready  = 1'b1;
    m1_awvalid = 1'b0;
    m1_awaddr  = '0;
    m1_wvalid  = 1'b0;
    m1_wdata   = '0;
    m1_wstrb   = '0;
    m1_bready  = 1'b1;
    m0_pend    = 1'b0;
    m1_pend    = 1'b0;
    last_grant = 1'b1;
    mon_awaddr = '0;
    repeat (2) @(posedge aclk);
    arst_n <= 1'b1;
    @(posedge aclk);

    // Full-word writes read back on m1
    repeat (16) begin
      word = $urandom_range(`MEM_DEPTH-1);
      write_word(word_addr(word), {$urandom, $urandom}, '1, `RESP_OKAY);
      read_both(1'b0, 1'b1, '0, word_addr(word), 0);
      written.push_back(word);
    end

    // Partial strobes over known words
    repeat (16) begin
      word = written[$urandom_range(written.size()-1)];
      write_word(word_addr(word), {$urandom, $urandom}, axil_mem_pkg::strb_t'($urandom),
                 `RESP_OKAY);
      read_both(1'b0, 1'b1, '0, word_addr(word), 0);
    end

    // Out-of-range access followed by a read of the aliased low word
    repeat (8) begin
      word       = written[$urandom_range(written.size()-1)];
      alias_word = word + `MEM_DEPTH * $urandom_range(1, 4000);
      write_word(word_addr(alias_word), {$urandom, $urandom}, '1, `RESP_SLVERR);
      read_both(1'b0, 1'b1, '0, word_addr(alias_word), 0);
      read_both(1'b0, 1'b1, '0, word_addr(word), 0);
    end

    // Back-pressure on both read ports
    repeat (8) begin
      word = written[$urandom_range(written.size()-1)];
      read_both(1'b0, 1'b1, '0, word_addr(word), $urandom_range(1, 6));
      read_both(1'b1, 1'b0, word_addr(word), '0, $urandom_range(1, 6));
    end

    // Simultaneous requests with a lone m0 read every other round to flip the priority
    for (int i = 0; i < 12; i++) begin
      if (i % 2 == 1) read_both(1'b1, 1'b0, word_addr(written[0]), '0, 0);
      read_both(1'b1, 1'b1, word_addr(written[$urandom_range(written.size()-1)]),
                word_addr(written[$urandom_range(written.size()-1)]), 0);
    end

    repeat (4) @(posedge aclk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
axil_mem_pkg.sv
sram_bytewise.sv
axil_sram_slave.sv
axil_rd_arbiter.sv
axil_mem_top.sv
tb_axil_mem.sv

// File: Bender.yml
package:
  name: axil_mem

export_include_dirs:
  - .

sources:
  - files:
      - axil_mem_pkg.sv
      - sram_bytewise.sv
      - axil_sram_slave.sv
      - axil_rd_arbiter.sv
      - axil_mem_top.sv
  - target: test
    files:
      - tb_axil_mem.sv
